//--- common/axi_defines.svh
`ifndef AXI_DEFINES_SVH
`define AXI_DEFINES_SVH

// bus widths
`define AXI_ADDR_WIDTH 32
`define AXI_DATA_WIDTH 32
`define AXI_STRB_WIDTH 4
`define AXI_ID_WIDTH 6

// ports on each side of the switch
`define AXI_NUM_PORTS 3

// upper field names the master, lower field the slave
`define AXI_ROUTE_FIELD_WIDTH 3

`endif

//--- common/axi_types_pkg.sv
`include "axi_defines.svh"

package axi_types_pkg;

    typedef logic [`AXI_ID_WIDTH-1:0] axi_id_t;

    //********************************************************************
    // channel payloads
    //********************************************************************

    // address channel, shared by write and read address
    typedef struct packed {
        logic [`AXI_ADDR_WIDTH-1:0] addr;
        logic [7:0]                 len;
        logic [2:0]                 size;
        logic [1:0]                 burst;
    } aw_payload_t;

    typedef struct packed {
        logic [`AXI_DATA_WIDTH-1:0] data;
        logic [`AXI_STRB_WIDTH-1:0] strb;
        logic                       last;
    } w_payload_t;

    typedef struct packed {
        logic [`AXI_DATA_WIDTH-1:0] data;
        logic [1:0]                 resp;
        logic                       last;
    } r_payload_t;

    // write response carries the response code only
    typedef struct packed {
        logic [1:0] resp;
    } b_payload_t;

endpackage

//--- common/axi_route_pkg.sv
`include "axi_defines.svh"

package axi_route_pkg;

    typedef logic [`AXI_ROUTE_FIELD_WIDTH-1:0] route_field_t;

    // one bit per port, all zero when nothing matches
    typedef logic [`AXI_NUM_PORTS-1:0] port_sel_t;

    // which half of the id names the source
    typedef enum logic {
        field_master = 1'b0,
        field_slave  = 1'b1
    } field_sel_e;

    // thermometer codes for ports 0, 1 and 2
    localparam route_field_t port_code [`AXI_NUM_PORTS] = '{
        3'b001,
        3'b011,
        3'b111
    };

    // field positions inside the id
    localparam int master_field_lsb = `AXI_ID_WIDTH - `AXI_ROUTE_FIELD_WIDTH;
    localparam int slave_field_lsb  = 0;

endpackage

//--- switch/axi_route_decode.sv
`timescale 1ns/100ps
`include "axi_defines.svh"

module axi_route_decode #(
    parameter axi_route_pkg::field_sel_e src_field = axi_route_pkg::field_master
) (
    input  logic                     aclk,
    input  logic                     reset,
    input  axi_types_pkg::axi_id_t   id [`AXI_NUM_PORTS],
    output axi_route_pkg::port_sel_t src_sel,
    output axi_route_pkg::port_sel_t dst_sel
);
    import axi_types_pkg::*;
    import axi_route_pkg::*;

    axi_id_t      id_or;
    route_field_t master_code;
    route_field_t slave_code;
    route_field_t src_code;
    route_field_t dst_code;

    // idle sources drive zero ids, so the OR is the active id
    always_comb begin
        id_or = '0;
        for (int i = 0; i < `AXI_NUM_PORTS; i++) begin
            id_or = id_or | id[i];
        end
    end

    assign master_code = id_or[master_field_lsb +: `AXI_ROUTE_FIELD_WIDTH];
    assign slave_code  = id_or[slave_field_lsb +: `AXI_ROUTE_FIELD_WIDTH];

    // responses travel back, so the fields swap roles
    assign src_code = (src_field == field_slave) ? slave_code : master_code;
    assign dst_code = (src_field == field_master) ? slave_code : master_code;

    //********************************************************************
    // thermometer match, unknown codes select nothing
    //********************************************************************
    for (genvar p = 0; p < `AXI_NUM_PORTS; p++) begin : g_match
        assign src_sel[p] = (src_code == port_code[p]);
        assign dst_sel[p] = (dst_code == port_code[p]);
    end

    a_src_sel_onehot: assert property (
        @(posedge aclk) disable iff (reset) $onehot0(src_sel)
    ) else $error("source select has more than one bit set: %h", src_sel);

    a_dst_sel_onehot: assert property (
        @(posedge aclk) disable iff (reset) $onehot0(dst_sel)
    ) else $error("destination select has more than one bit set: %h", dst_sel);

endmodule

//--- switch/axi_channel_switch.sv
`timescale 1ns/100ps
`include "axi_defines.svh"

module axi_channel_switch #(
    parameter type                       payload_t = logic,
    parameter axi_route_pkg::field_sel_e src_field = axi_route_pkg::field_master
) (
    input  logic                   aclk,
    input  logic                   reset,

    input  logic                   src_valid   [`AXI_NUM_PORTS],
    output logic                   src_ready   [`AXI_NUM_PORTS],
    input  payload_t               src_payload [`AXI_NUM_PORTS],
    input  axi_types_pkg::axi_id_t src_id      [`AXI_NUM_PORTS],

    output logic                   dst_valid   [`AXI_NUM_PORTS],
    input  logic                   dst_ready   [`AXI_NUM_PORTS],
    output payload_t               dst_payload [`AXI_NUM_PORTS],
    output axi_types_pkg::axi_id_t dst_id      [`AXI_NUM_PORTS]
);
    import axi_types_pkg::*;
    import axi_route_pkg::*;

    port_sel_t src_sel;
    port_sel_t dst_sel;

    logic      mux_valid;
    payload_t  mux_payload;
    axi_id_t   mux_id;
    logic      mux_ready;

    // packed copies for the checks below
    port_sel_t dst_valid_vec;
    port_sel_t src_ready_vec;

    // sources whose own id names them
    port_sel_t src_own;

    axi_route_decode #(
        .src_field (src_field)
    ) i_route_decode (
        .aclk    (aclk),
        .reset   (reset),
        .id      (src_id),
        .src_sel (src_sel),
        .dst_sel (dst_sel)
    );

    //********************************************************************
    // source side mux
    //********************************************************************
    always_comb begin
        mux_valid   = 1'b0;
        mux_payload = '0;
        mux_id      = '0;
        for (int i = 0; i < `AXI_NUM_PORTS; i++) begin
            if (src_sel[i]) begin
                mux_valid   = src_valid[i];
                mux_payload = src_payload[i];
                mux_id      = src_id[i];
            end
        end
    end

    // ready from the selected destination
    always_comb begin
        mux_ready = 1'b0;
        for (int i = 0; i < `AXI_NUM_PORTS; i++) begin
            if (dst_sel[i]) begin
                mux_ready = dst_ready[i];
            end
        end
    end

    //********************************************************************
    // fan out, zero on every unselected port
    //********************************************************************
    for (genvar p = 0; p < `AXI_NUM_PORTS; p++) begin : g_port
        assign src_ready[p]   = src_sel[p] & mux_ready;
        assign dst_valid[p]   = dst_sel[p] & mux_valid;
        assign dst_payload[p] = dst_sel[p] ? mux_payload : '0;
        assign dst_id[p]      = dst_sel[p] ? mux_id : '0;

        assign dst_valid_vec[p] = dst_valid[p];
        assign src_ready_vec[p] = src_ready[p];

        assign src_own[p] = (src_field == field_master)
            ? (src_id[p][master_field_lsb +: `AXI_ROUTE_FIELD_WIDTH] == port_code[p])
            : (src_id[p][slave_field_lsb +: `AXI_ROUTE_FIELD_WIDTH] == port_code[p]);
    end

    a_dst_valid_onehot: assert property (
        @(posedge aclk) disable iff (reset) $onehot0(dst_valid_vec)
    ) else $error("more than one destination valid: %h", dst_valid_vec);

    a_ready_selected_only: assert property (
        @(posedge aclk) disable iff (reset) (src_ready_vec & ~src_own) == '0
    ) else $error("ready to unselected source: ready %h own %h", src_ready_vec, src_own);

endmodule

//--- src/axi_interconnect_3x3.sv
`timescale 1ns/100ps
`include "axi_defines.svh"

module axi_interconnect_3x3 (
    input  logic                       aclk,
    input  logic                       reset,

    // masters
    input  logic                       m_awvalid [`AXI_NUM_PORTS],
    output logic                       m_awready [`AXI_NUM_PORTS],
    input  axi_types_pkg::aw_payload_t m_aw      [`AXI_NUM_PORTS],
    input  axi_types_pkg::axi_id_t     m_awid    [`AXI_NUM_PORTS],

    input  logic                       m_wvalid  [`AXI_NUM_PORTS],
    output logic                       m_wready  [`AXI_NUM_PORTS],
    input  axi_types_pkg::w_payload_t  m_w       [`AXI_NUM_PORTS],
    input  axi_types_pkg::axi_id_t     m_wid     [`AXI_NUM_PORTS],

    input  logic                       m_arvalid [`AXI_NUM_PORTS],
    output logic                       m_arready [`AXI_NUM_PORTS],
    input  axi_types_pkg::aw_payload_t m_ar      [`AXI_NUM_PORTS],
    input  axi_types_pkg::axi_id_t     m_arid    [`AXI_NUM_PORTS],

    output logic                       m_rvalid  [`AXI_NUM_PORTS],
    input  logic                       m_rready  [`AXI_NUM_PORTS],
    output axi_types_pkg::r_payload_t  m_r       [`AXI_NUM_PORTS],
    output axi_types_pkg::axi_id_t     m_rid     [`AXI_NUM_PORTS],

    output logic                       m_bvalid  [`AXI_NUM_PORTS],
    input  logic                       m_bready  [`AXI_NUM_PORTS],
    output axi_types_pkg::b_payload_t  m_b       [`AXI_NUM_PORTS],
    output axi_types_pkg::axi_id_t     m_bid     [`AXI_NUM_PORTS],

    // slaves
    output logic                       s_awvalid [`AXI_NUM_PORTS],
    input  logic                       s_awready [`AXI_NUM_PORTS],
    output axi_types_pkg::aw_payload_t s_aw      [`AXI_NUM_PORTS],
    output axi_types_pkg::axi_id_t     s_awid    [`AXI_NUM_PORTS],

    output logic                       s_wvalid  [`AXI_NUM_PORTS],
    input  logic                       s_wready  [`AXI_NUM_PORTS],
    output axi_types_pkg::w_payload_t  s_w       [`AXI_NUM_PORTS],
    output axi_types_pkg::axi_id_t     s_wid     [`AXI_NUM_PORTS],

    output logic                       s_arvalid [`AXI_NUM_PORTS],
    input  logic                       s_arready [`AXI_NUM_PORTS],
    output axi_types_pkg::aw_payload_t s_ar      [`AXI_NUM_PORTS],
    output axi_types_pkg::axi_id_t     s_arid    [`AXI_NUM_PORTS],

    input  logic                       s_rvalid  [`AXI_NUM_PORTS],
    output logic                       s_rready  [`AXI_NUM_PORTS],
    input  axi_types_pkg::r_payload_t  s_r       [`AXI_NUM_PORTS],
    input  axi_types_pkg::axi_id_t     s_rid     [`AXI_NUM_PORTS],

    input  logic                       s_bvalid  [`AXI_NUM_PORTS],
    output logic                       s_bready  [`AXI_NUM_PORTS],
    input  axi_types_pkg::b_payload_t  s_b       [`AXI_NUM_PORTS],
    input  axi_types_pkg::axi_id_t     s_bid     [`AXI_NUM_PORTS]
);
    import axi_types_pkg::*;
    import axi_route_pkg::*;

    //********************************************************************
    // request channels, master to slave
    //********************************************************************
    axi_channel_switch #(
        .payload_t (aw_payload_t),
        .src_field (field_master)
    ) i_aw_switch (
        .aclk        (aclk),
        .reset       (reset),
        .src_valid   (m_awvalid),
        .src_ready   (m_awready),
        .src_payload (m_aw),
        .src_id      (m_awid),
        .dst_valid   (s_awvalid),
        .dst_ready   (s_awready),
        .dst_payload (s_aw),
        .dst_id      (s_awid)
    );

    axi_channel_switch #(
        .payload_t (w_payload_t),
        .src_field (field_master)
    ) i_w_switch (
        .aclk        (aclk),
        .reset       (reset),
        .src_valid   (m_wvalid),
        .src_ready   (m_wready),
        .src_payload (m_w),
        .src_id      (m_wid),
        .dst_valid   (s_wvalid),
        .dst_ready   (s_wready),
        .dst_payload (s_w),
        .dst_id      (s_wid)
    );

    // read address shares the write address payload
    axi_channel_switch #(
        .payload_t (aw_payload_t),
        .src_field (field_master)
    ) i_ar_switch (
        .aclk        (aclk),
        .reset       (reset),
        .src_valid   (m_arvalid),
        .src_ready   (m_arready),
        .src_payload (m_ar),
        .src_id      (m_arid),
        .dst_valid   (s_arvalid),
        .dst_ready   (s_arready),
        .dst_payload (s_ar),
        .dst_id      (s_arid)
    );

    //********************************************************************
    // response channels, slave back to master
    //********************************************************************
    axi_channel_switch #(
        .payload_t (r_payload_t),
        .src_field (field_slave)
    ) i_r_switch (
        .aclk        (aclk),
        .reset       (reset),
        .src_valid   (s_rvalid),
        .src_ready   (s_rready),
        .src_payload (s_r),
        .src_id      (s_rid),
        .dst_valid   (m_rvalid),
        .dst_ready   (m_rready),
        .dst_payload (m_r),
        .dst_id      (m_rid)
    );

    // bvalid comes from the slave's own bvalid
    axi_channel_switch #(
        .payload_t (b_payload_t),
        .src_field (field_slave)
    ) i_b_switch (
        .aclk        (aclk),
        .reset       (reset),
        .src_valid   (s_bvalid),
        .src_ready   (s_bready),
        .src_payload (s_b),
        .src_id      (s_bid),
        .dst_valid   (m_bvalid),
        .dst_ready   (m_bready),
        .dst_payload (m_b),
        .dst_id      (m_bid)
    );

endmodule

//--- bench/axi_interconnect_checker.sv
`timescale 1ns/100ps
`include "axi_defines.svh"

module axi_interconnect_checker #(
    parameter type                       payload_t    = logic,
    parameter axi_route_pkg::field_sel_e src_field    = axi_route_pkg::field_master,
    parameter string                     chan_name    = "aw",
    parameter int                        sample_delay = 35
) (
    input  logic                   aclk,
    input  logic                   reset,
    input  logic                   src_valid   [`AXI_NUM_PORTS],
    input  logic                   src_ready   [`AXI_NUM_PORTS],
    input  payload_t               src_payload [`AXI_NUM_PORTS],
    input  axi_types_pkg::axi_id_t src_id      [`AXI_NUM_PORTS],
    input  logic                   dst_valid   [`AXI_NUM_PORTS],
    input  logic                   dst_ready   [`AXI_NUM_PORTS],
    input  payload_t               dst_payload [`AXI_NUM_PORTS],
    input  axi_types_pkg::axi_id_t dst_id      [`AXI_NUM_PORTS],
    output int                     errors
);
    import axi_types_pkg::*;
    import axi_route_pkg::*;

    // port number of a thermometer code, -1 when the code names no port
    function automatic int port_of(input logic [2:0] code);
        case (code)
            3'b001:  return 0;
            3'b011:  return 1;
            3'b111:  return 2;
            default: return -1;
        endcase
    endfunction

    task automatic compare(input string sig, input int idx, input logic [63:0] exp,
                           input logic [63:0] got);
        if (exp !== got) begin
            errors++;
            $display("CHECK FAILED %s %s[%0d] expected %h got %h", chan_name, sig, idx, exp, got);
        end
    endtask

    initial errors = 0;

    //**********************************************************************
    // reference routing, sampled just before the next rising edge
    //**********************************************************************
    always begin
        int         busy;
        int         s;
        int         d;
        axi_id_t    id_or;
        logic       exp_bit;
        payload_t   exp_payload;
        axi_id_t    exp_id;
        @(posedge aclk);
        #(sample_delay);
        if (!reset) begin
            busy  = 0;
            id_or = '0;
            for (int i = 0; i < `AXI_NUM_PORTS; i++) begin
                if (src_valid[i] || src_id[i] != '0 || src_payload[i] != '0) begin
                    busy++;
                end
                id_or = id_or | src_id[i];
            end
            if (busy > 1) begin
                errors++;
                $display("stimulus error on %s: more than one source is not idle", chan_name);
            end
            if (src_field == field_master) begin
                s = port_of(id_or[5:3]);
                d = port_of(id_or[2:0]);
            end else begin
                s = port_of(id_or[2:0]);
                d = port_of(id_or[5:3]);
            end
            for (int p = 0; p < `AXI_NUM_PORTS; p++) begin
                exp_bit     = 1'b0;
                exp_payload = '0;
                exp_id      = '0;
                if (s >= 0 && d == p) begin
                    exp_bit     = src_valid[s];
                    exp_payload = src_payload[s];
                    exp_id      = src_id[s];
                end
                compare("dst_valid", p, 64'(exp_bit), 64'(dst_valid[p]));
                compare("dst_payload", p, 64'(exp_payload), 64'(dst_payload[p]));
                compare("dst_id", p, 64'(exp_id), 64'(dst_id[p]));
                // ready only back to the selected source
                exp_bit = 1'b0;
                if (d >= 0 && s == p) begin
                    exp_bit = dst_ready[d];
                end
                compare("src_ready", p, 64'(exp_bit), 64'(src_ready[p]));
            end
        end
    end

endmodule

//--- bench/tb_axi_interconnect.sv
`timescale 1ns/100ps
`include "axi_defines.svh"

module tb_axi_interconnect;
    import axi_types_pkg::*;
    import axi_route_pkg::*;

    localparam int num_ports    = `AXI_NUM_PORTS;
    localparam int num_rows     = 44;
    localparam int clk_period   = 40;
    localparam int reset_cycles = 5;

    logic        aclk;
    logic        reset;
    logic        m_awvalid [num_ports], m_awready [num_ports];
    logic        s_awvalid [num_ports], s_awready [num_ports];
    aw_payload_t m_aw [num_ports], s_aw [num_ports];
    axi_id_t     m_awid [num_ports], s_awid [num_ports];
    logic        m_wvalid [num_ports], m_wready [num_ports];
    logic        s_wvalid [num_ports], s_wready [num_ports];
    w_payload_t  m_w [num_ports], s_w [num_ports];
    axi_id_t     m_wid [num_ports], s_wid [num_ports];
    logic        m_arvalid [num_ports], m_arready [num_ports];
    logic        s_arvalid [num_ports], s_arready [num_ports];
    aw_payload_t m_ar [num_ports], s_ar [num_ports];
    axi_id_t     m_arid [num_ports], s_arid [num_ports];
    logic        m_rvalid [num_ports], m_rready [num_ports];
    logic        s_rvalid [num_ports], s_rready [num_ports];
    r_payload_t  m_r [num_ports], s_r [num_ports];
    axi_id_t     m_rid [num_ports], s_rid [num_ports];
    logic        m_bvalid [num_ports], m_bready [num_ports];
    logic        s_bvalid [num_ports], s_bready [num_ports];
    b_payload_t  m_b [num_ports], s_b [num_ports];
    axi_id_t     m_bid [num_ports], s_bid [num_ports];

    int aw_errors;
    int w_errors;
    int ar_errors;
    int r_errors;
    int b_errors;
    int total_errors;

    //**********************************************************************
    // stimulus rows: channel, source code, destination code, destination ready
    // channels 0 aw, 1 w, 2 ar, 3 r, 4 b
    //**********************************************************************
    localparam logic [9:0] rows [num_rows] = '{
        {3'd0, 3'b001, 3'b001, 1'b1}, {3'd0, 3'b001, 3'b011, 1'b0}, {3'd0, 3'b001, 3'b111, 1'b1},
        {3'd0, 3'b011, 3'b001, 1'b1}, {3'd0, 3'b011, 3'b011, 1'b1}, {3'd0, 3'b011, 3'b111, 1'b0},
        {3'd0, 3'b111, 3'b001, 1'b0}, {3'd0, 3'b111, 3'b011, 1'b1}, {3'd0, 3'b111, 3'b111, 1'b1},
        {3'd1, 3'b001, 3'b001, 1'b0}, {3'd1, 3'b001, 3'b011, 1'b1}, {3'd1, 3'b001, 3'b111, 1'b1},
        {3'd1, 3'b011, 3'b001, 1'b1}, {3'd1, 3'b011, 3'b011, 1'b0}, {3'd1, 3'b011, 3'b111, 1'b1},
        {3'd1, 3'b111, 3'b001, 1'b1}, {3'd1, 3'b111, 3'b011, 1'b1}, {3'd1, 3'b111, 3'b111, 1'b0},
        {3'd2, 3'b001, 3'b001, 1'b1}, {3'd2, 3'b001, 3'b011, 1'b1}, {3'd2, 3'b001, 3'b111, 1'b0},
        {3'd2, 3'b011, 3'b001, 1'b0}, {3'd2, 3'b011, 3'b011, 1'b1}, {3'd2, 3'b011, 3'b111, 1'b1},
        {3'd2, 3'b111, 3'b001, 1'b1}, {3'd2, 3'b111, 3'b011, 1'b0}, {3'd2, 3'b111, 3'b111, 1'b1},
        {3'd3, 3'b001, 3'b001, 1'b1}, {3'd3, 3'b011, 3'b011, 1'b0}, {3'd3, 3'b111, 3'b111, 1'b1},
        {3'd3, 3'b001, 3'b111, 1'b1}, {3'd3, 3'b111, 3'b001, 1'b1}, {3'd3, 3'b011, 3'b001, 1'b0},
        {3'd4, 3'b001, 3'b011, 1'b1}, {3'd4, 3'b011, 3'b111, 1'b1}, {3'd4, 3'b111, 3'b011, 1'b0},
        {3'd4, 3'b001, 3'b001, 1'b1}, {3'd4, 3'b111, 3'b111, 1'b1}, {3'd4, 3'b011, 3'b001, 1'b1},
        {3'd0, 3'b000, 3'b001, 1'b1}, {3'd1, 3'b011, 3'b010, 1'b1}, {3'd2, 3'b100, 3'b111, 1'b1},
        {3'd3, 3'b101, 3'b001, 1'b1}, {3'd4, 3'b001, 3'b110, 1'b1}
    };

    axi_interconnect_3x3 i_axi_interconnect_3x3 (.*);

    axi_interconnect_checker #(.payload_t(aw_payload_t), .src_field(field_master),
                               .chan_name("aw")) i_check_aw (
        .aclk(aclk), .reset(reset), .errors(aw_errors),
        .src_valid(m_awvalid), .src_ready(m_awready), .src_payload(m_aw), .src_id(m_awid),
        .dst_valid(s_awvalid), .dst_ready(s_awready), .dst_payload(s_aw), .dst_id(s_awid)
    );
    axi_interconnect_checker #(.payload_t(w_payload_t), .src_field(field_master),
                               .chan_name("w")) i_check_w (
        .aclk(aclk), .reset(reset), .errors(w_errors),
        .src_valid(m_wvalid), .src_ready(m_wready), .src_payload(m_w), .src_id(m_wid),
        .dst_valid(s_wvalid), .dst_ready(s_wready), .dst_payload(s_w), .dst_id(s_wid)
    );
    axi_interconnect_checker #(.payload_t(aw_payload_t), .src_field(field_master),
                               .chan_name("ar")) i_check_ar (
        .aclk(aclk), .reset(reset), .errors(ar_errors),
        .src_valid(m_arvalid), .src_ready(m_arready), .src_payload(m_ar), .src_id(m_arid),
        .dst_valid(s_arvalid), .dst_ready(s_arready), .dst_payload(s_ar), .dst_id(s_arid)
    );
    axi_interconnect_checker #(.payload_t(r_payload_t), .src_field(field_slave),
                               .chan_name("r")) i_check_r (
        .aclk(aclk), .reset(reset), .errors(r_errors),
        .src_valid(s_rvalid), .src_ready(s_rready), .src_payload(s_r), .src_id(s_rid),
        .dst_valid(m_rvalid), .dst_ready(m_rready), .dst_payload(m_r), .dst_id(m_rid)
    );
    axi_interconnect_checker #(.payload_t(b_payload_t), .src_field(field_slave),
                               .chan_name("b")) i_check_b (
        .aclk(aclk), .reset(reset), .errors(b_errors),
        .src_valid(s_bvalid), .src_ready(s_bready), .src_payload(s_b), .src_id(s_bid),
        .dst_valid(m_bvalid), .dst_ready(m_bready), .dst_payload(m_b), .dst_id(m_bid)
    );

    // unknown codes still need some port to drive from
    function automatic int drive_port(input route_field_t code);
        case (code)
            3'b011:  return 1;
            3'b111:  return 2;
            default: return 0;
        endcase
    endfunction

    function automatic aw_payload_t random_addr();
        aw_payload_t p;
        p.addr  = $urandom;
        p.len   = 8'($urandom);
        // size kept apart from the low length bits
        p.size  = p.len[2:0] + 3'd1;
        p.burst = 2'($urandom_range(2));
        return p;
    endfunction

    task automatic clear_inputs();
        for (int i = 0; i < num_ports; i++) begin
            m_awvalid[i] = 1'b0;
            m_aw[i]      = '0;
            m_awid[i]    = '0;
            m_wvalid[i]  = 1'b0;
            m_w[i]       = '0;
            m_wid[i]     = '0;
            m_arvalid[i] = 1'b0;
            m_ar[i]      = '0;
            m_arid[i]    = '0;
            m_rready[i]  = 1'b0;
            m_bready[i]  = 1'b0;
            s_awready[i] = 1'b0;
            s_wready[i]  = 1'b0;
            s_arready[i] = 1'b0;
            s_rvalid[i]  = 1'b0;
            s_r[i]       = '0;
            s_rid[i]     = '0;
            s_bvalid[i]  = 1'b0;
            s_b[i]       = '0;
            s_bid[i]     = '0;
        end
    endtask

    task automatic apply_row(input logic [9:0] row);
        logic [2:0]   chan;
        route_field_t src_code;
        route_field_t dst_code;
        int           sp;
        int           dp;
        logic         vld;
        chan     = row[9:7];
        src_code = row[6:4];
        dst_code = row[3:1];
        sp       = drive_port(src_code);
        dp       = drive_port(dst_code);
        vld      = ($urandom_range(3) != 0);
        clear_inputs();
        case (chan)
            3'd0: begin
                m_awvalid[sp] = vld;
                m_aw[sp]      = random_addr();
                m_awid[sp]    = {src_code, dst_code};
                s_awready[dp] = row[0];
            end
            3'd1: begin
                m_wvalid[sp] = vld;
                m_w[sp]      = {$urandom, 4'($urandom), 1'($urandom)};
                m_wid[sp]    = {src_code, dst_code};
                s_wready[dp] = row[0];
            end
            3'd2: begin
                m_arvalid[sp] = vld;
                m_ar[sp]      = random_addr();
                m_arid[sp]    = {src_code, dst_code};
                s_arready[dp] = row[0];
            end
            // responses carry the master in the upper field
            3'd3: begin
                s_rvalid[sp] = vld;
                s_r[sp]      = {$urandom, 2'($urandom), 1'($urandom)};
                s_rid[sp]    = {dst_code, src_code};
                m_rready[dp] = row[0];
            end
            default: begin
                s_bvalid[sp] = vld;
                s_b[sp]      = 2'($urandom);
                s_bid[sp]    = {dst_code, src_code};
                m_bready[dp] = row[0];
            end
        endcase
    endtask

    initial begin
        aclk = 1'b0;
        forever #(clk_period / 2) aclk = ~aclk;
    end

    initial begin
        void'($urandom(32'h89528e70));
        clear_inputs();
        reset = 1'b1;
        repeat (reset_cycles) @(posedge aclk);
        #1;
        reset = 1'b0;
        for (int r = 0; r < num_rows; r++) begin
            @(posedge aclk);
            #1;
            apply_row(rows[r]);
        end
        @(posedge aclk);
        #1;
        clear_inputs();
        repeat (2) @(posedge aclk);
        total_errors = aw_errors + w_errors + ar_errors + r_errors + b_errors;
        $display("errors aw %0d w %0d ar %0d r %0d b %0d total %0d",
                 aw_errors, w_errors, ar_errors, r_errors, b_errors, total_errors);
        if (total_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // watchdog
    initial begin
        #((2 * num_rows + reset_cycles) * clk_period);
        $display("run did not finish before the watchdog time ran out");
        $display("** FAIL **");
        $finish;
    end

endmodule

//--- axi_interconnect.f
+incdir+common
common/axi_types_pkg.sv
common/axi_route_pkg.sv
switch/axi_route_decode.sv
switch/axi_channel_switch.sv
src/axi_interconnect_3x3.sv
bench/axi_interconnect_checker.sv
bench/tb_axi_interconnect.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the interconnect testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f axi_interconnect.f \
    --top-module tb_axi_interconnect \
    -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

output=$(./obj_dir/Vtb_axi_interconnect)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qxF "** PASS **"; then
    exit 0
fi
exit 1
